// ==== Makefile ====
# Verilator build of the rv_core testbench

SIM := obj_dir/Vtb_rv_core

.PHONY: all run clean

all: $(SIM)

# Rebuilt only when the file list or a listed source changes
$(SIM): build.f $(shell grep -v '^+' build.f)
	verilator --binary --timing --assert --top-module tb_rv_core \
		-f build.f -Mdir obj_dir -o Vtb_rv_core

# Exit status comes from the search for the pass line
run: $(SIM)
	./$(SIM) | tee /dev/stderr | grep -q "ALL TESTS PASSED"

clean:
	rm -rf obj_dir

// ==== build.f ====
common/rv_pkg.sv
src/fetch_stage.sv
src/decode_stage.sv
src/execute_stage.sv
src/hazard_unit.sv
src/memory_stage.sv
src/writeback_stage.sv
src/rv_core.sv
testbench/rv_core_checker.sv
testbench/tb_rv_core.sv

// ==== common/rv_pkg.sv ====
// RV32I subset only (no CSR, no traps, word-sized memory access only); all widths fixed at 32 bits
package rv_pkg;

  // ====================
  // Widths and constants
  // ====================
  localparam int unsigned XLEN = 32;

  typedef logic [XLEN-1:0] word_t;
  typedef logic [4:0]      reg_addr_t;

  // First fetch address after reset
  localparam word_t RESET_PC = 32'h0000_0000;
  // ADDI x0,x0,0 fills a flushed fetch slot
  localparam word_t NOP_INSTR = 32'h0000_0013;

  // Major opcodes of the supported subset
  localparam logic [6:0] OPC_LUI    = 7'b0110111;
  localparam logic [6:0] OPC_JAL    = 7'b1101111;
  localparam logic [6:0] OPC_JALR   = 7'b1100111;
  localparam logic [6:0] OPC_BRANCH = 7'b1100011;
  localparam logic [6:0] OPC_LOAD   = 7'b0000011;
  localparam logic [6:0] OPC_STORE  = 7'b0100011;
  localparam logic [6:0] OPC_OPIMM  = 7'b0010011;
  localparam logic [6:0] OPC_OP     = 7'b0110011;

  // ====================
  // Control encodings
  // ====================
  // Zero encodings double as the bubble value of every pipeline register
  typedef enum logic [3:0] {
    ALU_ADD, ALU_SUB, ALU_AND, ALU_OR, ALU_XOR,
    ALU_SLL, ALU_SRL, ALU_SRA, ALU_SLT, ALU_SLTU,
    ALU_PASS_B
  } alu_op_e;

  typedef enum logic [3:0] {
    BR_NONE, BR_EQ, BR_NE, BR_LT, BR_GE, BR_LTU, BR_GEU, BR_JAL, BR_JALR
  } branch_e;

  typedef enum logic [1:0] {
    RES_ALU, RES_LOAD, RES_PC4
  } result_src_e;

  typedef enum logic [1:0] {
    FWD_RF, FWD_MEM, FWD_WB
  } fwd_sel_e;

  // ====================
  // Pipeline bundles
  // ====================
  typedef struct packed {
    logic        reg_write;
    logic        mem_write;
    logic        mem_read;
    alu_op_e     alu_op;
    logic        imm_b;       // Operand B from the immediate
    result_src_e result_src;
    branch_e     branch;
  } ctrl_t;

  typedef struct packed {
    word_t pc;
    word_t instr;
  } if_id_t;

  typedef struct packed {
    ctrl_t     ctrl;
    word_t     pc;
    word_t     rs1_val;
    word_t     rs2_val;
    word_t     imm;
    reg_addr_t rs1;
    reg_addr_t rs2;
    reg_addr_t rd;
  } id_ex_t;

  typedef struct packed {
    logic        reg_write;
    result_src_e result_src;
    logic        mem_write;
    logic        mem_read;
    word_t       alu_result;
    word_t       store_data;
    word_t       pc4;
    reg_addr_t   rd;
  } ex_mem_t;

  typedef struct packed {
    logic        reg_write;
    result_src_e result_src;
    word_t       alu_result;
    word_t       load_data;
    word_t       pc4;
    reg_addr_t   rd;
  } mem_wb_t;

  // Data port request, strobes are single-cycle levels
  typedef struct packed {
    word_t addr;
    word_t wdata;
    logic  we;
    logic  re;
  } dmem_req_t;

  typedef struct packed {
    logic      en;
    reg_addr_t rd;
    word_t     data;
  } rf_write_t;

endpackage

// ==== src/decode_stage.sv ====
// Register file has no reset, so software must write a register before reading it
`timescale 1ns/1ns
module decode_stage
  import rv_pkg::*;
(
  input  logic      clk_i,
  input  logic      rst_ni,
  input  if_id_t    fetch_i,
  input  logic      stall_i,
  input  logic      flush_i,
  input  rf_write_t rf_write_i,
  output reg_addr_t rs1_o,
  output reg_addr_t rs2_o,
  output id_ex_t    decoded_o
);

  if_id_t     if_id_q;
  word_t      instr;
  logic [6:0] opcode;
  logic [2:0] funct3;
  logic [6:0] funct7;
  ctrl_t      ctrl;
  word_t      imm;
  logic       use_rs1;
  logic       use_rs2;
  reg_addr_t  rs1;
  reg_addr_t  rs2;
  word_t      rs1_val;
  word_t      rs2_val;
  word_t      rf_mem [32];

  // ====================
  // Fetch to decode register
  // ====================
  // Flush inserts a NOP, stall keeps the current word
  always_ff @(posedge clk_i) begin
    if (!rst_ni || flush_i) begin
      if_id_q <= '{pc: RESET_PC, instr: NOP_INSTR};
    end else if (!stall_i) begin
      if_id_q <= fetch_i;
    end
  end

  assign instr  = if_id_q.instr;
  assign opcode = instr[6:0];
  assign funct3 = instr[14:12];
  assign funct7 = instr[31:25];

  // ALU op from funct3, alt picks SUB or SRA
  function automatic alu_op_e alu_sel(input logic [2:0] f3, input logic alt);
    case (f3)
      3'b000:  alu_sel = alt ? ALU_SUB : ALU_ADD;
      3'b001:  alu_sel = ALU_SLL;
      3'b010:  alu_sel = ALU_SLT;
      3'b011:  alu_sel = ALU_SLTU;
      3'b100:  alu_sel = ALU_XOR;
      3'b101:  alu_sel = alt ? ALU_SRA : ALU_SRL;
      3'b110:  alu_sel = ALU_OR;
      default: alu_sel = ALU_AND;
    endcase
  endfunction

  // ====================
  // Decoder and immediates
  // ====================
  // Anything not matched keeps the all-zero control, which behaves as a NOP
  always_comb begin
    ctrl = '0;
    imm  = '0;
    case (opcode)
      OPC_LUI: begin
        ctrl.reg_write = 1'b1;
        ctrl.alu_op    = ALU_PASS_B;
        ctrl.imm_b     = 1'b1;
        imm            = {instr[31:12], 12'b0};
      end
      OPC_JAL: begin
        ctrl.reg_write  = 1'b1;
        ctrl.result_src = RES_PC4;
        ctrl.branch     = BR_JAL;
        imm = {{11{instr[31]}}, instr[31], instr[19:12], instr[20], instr[30:21], 1'b0};
      end
      OPC_JALR: begin
        if (funct3 == 3'b000) begin
          ctrl.reg_write  = 1'b1;
          ctrl.result_src = RES_PC4;
          ctrl.branch     = BR_JALR;
        end
        imm = {{20{instr[31]}}, instr[31:20]};
      end
      OPC_BRANCH: begin
        case (funct3)
          3'b000:  ctrl.branch = BR_EQ;
          3'b001:  ctrl.branch = BR_NE;
          3'b100:  ctrl.branch = BR_LT;
          3'b101:  ctrl.branch = BR_GE;
          3'b110:  ctrl.branch = BR_LTU;
          3'b111:  ctrl.branch = BR_GEU;
          default: ctrl.branch = BR_NONE;
        endcase
        imm = {{19{instr[31]}}, instr[31], instr[7], instr[30:25], instr[11:8], 1'b0};
      end
      OPC_LOAD: begin
        // Word loads only
        if (funct3 == 3'b010) begin
          ctrl.reg_write  = 1'b1;
          ctrl.mem_read   = 1'b1;
          ctrl.imm_b      = 1'b1;
          ctrl.result_src = RES_LOAD;
        end
        imm = {{20{instr[31]}}, instr[31:20]};
      end
      OPC_STORE: begin
        if (funct3 == 3'b010) begin
          ctrl.mem_write = 1'b1;
          ctrl.imm_b     = 1'b1;
        end
        imm = {{20{instr[31]}}, instr[31:25], instr[11:7]};
      end
      OPC_OPIMM: begin
        // Shift immediates need a clean funct7, SRAI allows bit 30
        if ((funct3 != 3'b001 && funct3 != 3'b101) || funct7 == 7'h00 ||
            (funct3 == 3'b101 && funct7 == 7'h20)) begin
          ctrl.reg_write = 1'b1;
          ctrl.imm_b     = 1'b1;
          ctrl.alu_op    = alu_sel(funct3, funct3 == 3'b101 && funct7[5]);
        end
        imm = {{20{instr[31]}}, instr[31:20]};
      end
      OPC_OP: begin
        if (funct7 == 7'h00 || (funct7 == 7'h20 && (funct3 == 3'b000 || funct3 == 3'b101))) begin
          ctrl.reg_write = 1'b1;
          ctrl.alu_op    = alu_sel(funct3, funct7[5]);
        end
      end
      default: begin
        ctrl = '0;
      end
    endcase
  end

  // Unused source fields read as x0 so they never cause a hazard
  assign use_rs1 = (opcode != OPC_LUI) && (opcode != OPC_JAL);
  assign use_rs2 = (opcode == OPC_OP) || (opcode == OPC_STORE) || (opcode == OPC_BRANCH);
  assign rs1     = use_rs1 ? instr[19:15] : 5'd0;
  assign rs2     = use_rs2 ? instr[24:20] : 5'd0;

  // ====================
  // Register file
  // ====================
  // Writeback never targets x0
  always_ff @(posedge clk_i) begin
    if (rf_write_i.en) begin
      rf_mem[rf_write_i.rd] <= rf_write_i.data;
    end
  end

  // Write-first bypass, x0 hardwired to zero
  always_comb begin
    if (rs1 == 5'd0) begin
      rs1_val = '0;
    end else if (rf_write_i.en && rf_write_i.rd == rs1) begin
      rs1_val = rf_write_i.data;
    end else begin
      rs1_val = rf_mem[rs1];
    end
    if (rs2 == 5'd0) begin
      rs2_val = '0;
    end else if (rf_write_i.en && rf_write_i.rd == rs2) begin
      rs2_val = rf_write_i.data;
    end else begin
      rs2_val = rf_mem[rs2];
    end
  end

  assign rs1_o = rs1;
  assign rs2_o = rs2;
  assign decoded_o = '{
    ctrl:    ctrl,
    pc:      if_id_q.pc,
    rs1_val: rs1_val,
    rs2_val: rs2_val,
    imm:     imm,
    rs1:     rs1,
    rs2:     rs2,
    rd:      instr[11:7]
  };

endmodule

// ==== src/execute_stage.sv ====
// Branches resolve here; a taken branch or jump costs two bubbles, misaligned targets are not trapped
`timescale 1ns/1ns
module execute_stage
  import rv_pkg::*;
(
  input  logic      clk_i,
  input  logic      rst_ni,
  input  id_ex_t    decoded_i,
  input  logic      bubble_i,
  input  fwd_sel_e  fwd_a_i,
  input  fwd_sel_e  fwd_b_i,
  input  word_t     mem_result_i,
  input  rf_write_t rf_write_i,
  output reg_addr_t rd_o,
  output logic      mem_read_o,
  output reg_addr_t rs1_o,
  output reg_addr_t rs2_o,
  output logic      redirect_o,
  output word_t     target_o,
  output ex_mem_t   ex_mem_o
);

  id_ex_t id_ex_q;
  word_t  op_a;
  word_t  op_b;
  word_t  alu_b;
  word_t  alu_res;
  logic   taken;

  // ====================
  // Decode to execute register
  // ====================
  // Bubble covers both the load-use slot and a redirect flush
  always_ff @(posedge clk_i) begin
    if (!rst_ni || bubble_i) begin
      id_ex_q <= '0;
    end else begin
      id_ex_q <= decoded_i;
    end
  end

  // Operand forwarding
  always_comb begin
    case (fwd_a_i)
      FWD_MEM: op_a = mem_result_i;
      FWD_WB:  op_a = rf_write_i.data;
      default: op_a = id_ex_q.rs1_val;
    endcase
    case (fwd_b_i)
      FWD_MEM: op_b = mem_result_i;
      FWD_WB:  op_b = rf_write_i.data;
      default: op_b = id_ex_q.rs2_val;
    endcase
  end

  assign alu_b = id_ex_q.ctrl.imm_b ? id_ex_q.imm : op_b;

  // ALU, shifts use the low five bits
  always_comb begin
    case (id_ex_q.ctrl.alu_op)
      ALU_SUB:    alu_res = op_a - alu_b;
      ALU_AND:    alu_res = op_a & alu_b;
      ALU_OR:     alu_res = op_a | alu_b;
      ALU_XOR:    alu_res = op_a ^ alu_b;
      ALU_SLL:    alu_res = op_a << alu_b[4:0];
      ALU_SRL:    alu_res = op_a >> alu_b[4:0];
      ALU_SRA:    alu_res = word_t'($signed(op_a) >>> alu_b[4:0]);
      ALU_SLT:    alu_res = {31'b0, $signed(op_a) < $signed(alu_b)};
      ALU_SLTU:   alu_res = {31'b0, op_a < alu_b};
      ALU_PASS_B: alu_res = alu_b;
      default:    alu_res = op_a + alu_b;
    endcase
  end

  // Branch compare always uses the register operands
  always_comb begin
    case (id_ex_q.ctrl.branch)
      BR_EQ:   taken = (op_a == op_b);
      BR_NE:   taken = (op_a != op_b);
      BR_LT:   taken = ($signed(op_a) < $signed(op_b));
      BR_GE:   taken = ($signed(op_a) >= $signed(op_b));
      BR_LTU:  taken = (op_a < op_b);
      BR_GEU:  taken = (op_a >= op_b);
      BR_JAL,
      BR_JALR: taken = 1'b1;
      default: taken = 1'b0;
    endcase
  end

  assign redirect_o = taken;
  // JALR clears bit 0 of rs1 + imm
  assign target_o = (id_ex_q.ctrl.branch == BR_JALR) ?
                    ((op_a + id_ex_q.imm) & ~32'd1) : (id_ex_q.pc + id_ex_q.imm);

  // Hazard unit taps
  assign rd_o       = id_ex_q.rd;
  assign mem_read_o = id_ex_q.ctrl.mem_read;
  assign rs1_o      = id_ex_q.rs1;
  assign rs2_o      = id_ex_q.rs2;

  assign ex_mem_o = '{
    reg_write:  id_ex_q.ctrl.reg_write,
    result_src: id_ex_q.ctrl.result_src,
    mem_write:  id_ex_q.ctrl.mem_write,
    mem_read:   id_ex_q.ctrl.mem_read,
    alu_result: alu_res,
    store_data: op_b,
    pc4:        id_ex_q.pc + 32'd4,
    rd:         id_ex_q.rd
  };

endmodule

// ==== src/fetch_stage.sv ====
// Instruction word must arrive combinationally for the current PC; predicts not-taken always
`timescale 1ns/1ns
module fetch_stage
  import rv_pkg::*;
(
  input  logic   clk_i,
  input  logic   rst_ni,
  input  logic   stall_i,
  input  logic   redirect_i,
  input  word_t  target_i,
  output word_t  imem_addr_o,
  input  word_t  imem_rdata_i,
  output if_id_t fetch_o
);

  word_t pc_q;
  word_t pc_d;

  // Redirect wins over a load-use hold
  always_comb begin
    if (redirect_i) begin
      pc_d = target_i;
    end else if (stall_i) begin
      pc_d = pc_q;
    end else begin
      pc_d = pc_q + 32'd4;
    end
  end

  always_ff @(posedge clk_i) begin
    if (!rst_ni) begin
      pc_q <= RESET_PC;
    end else begin
      pc_q <= pc_d;
    end
  end

  assign imem_addr_o = pc_q;
  // Registered in decode, not here
  assign fetch_o     = '{pc: pc_q, instr: imem_rdata_i};

endmodule

// ==== src/hazard_unit.sv ====
// Purely combinational; assumes load-use is the only stall source and resolves branches in execute
`timescale 1ns/1ns
module hazard_unit
  import rv_pkg::*;
(
  input  reg_addr_t id_rs1_i,
  input  reg_addr_t id_rs2_i,
  input  reg_addr_t ex_rs1_i,
  input  reg_addr_t ex_rs2_i,
  input  reg_addr_t ex_rd_i,
  input  logic      ex_mem_read_i,
  input  logic      redirect_i,
  input  reg_addr_t mem_rd_i,
  input  logic      mem_reg_write_i,
  input  reg_addr_t wb_rd_i,
  input  logic      wb_reg_write_i,
  output logic      stall_o,
  output logic      flush_id_o,
  output logic      bubble_ex_o,
  output fwd_sel_e  fwd_a_o,
  output fwd_sel_e  fwd_b_o
);

  logic load_use;

  // Youngest producer wins, x0 never forwards
  function automatic fwd_sel_e fwd_pick(input reg_addr_t rs, input reg_addr_t m_rd,
                                        input logic m_we, input reg_addr_t w_rd,
                                        input logic w_we);
    if (rs != 5'd0 && m_we && m_rd == rs) begin
      fwd_pick = FWD_MEM;
    end else if (rs != 5'd0 && w_we && w_rd == rs) begin
      fwd_pick = FWD_WB;
    end else begin
      fwd_pick = FWD_RF;
    end
  endfunction

  assign fwd_a_o = fwd_pick(ex_rs1_i, mem_rd_i, mem_reg_write_i, wb_rd_i, wb_reg_write_i);
  assign fwd_b_o = fwd_pick(ex_rs2_i, mem_rd_i, mem_reg_write_i, wb_rd_i, wb_reg_write_i);

  // Load result is not ready until writeback, so hold the consumer one cycle
  assign load_use = ex_mem_read_i && (ex_rd_i != 5'd0) &&
                    ((ex_rd_i == id_rs1_i) || (ex_rd_i == id_rs2_i));

  assign stall_o     = load_use;
  assign flush_id_o  = redirect_i;
  assign bubble_ex_o = load_use || redirect_i;

endmodule

// ==== src/memory_stage.sv ====
// Data port is word-only and single-cycle; address bits 1:0 are passed through unchecked
`timescale 1ns/1ns
module memory_stage
  import rv_pkg::*;
(
  input  logic      clk_i,
  input  logic      rst_ni,
  input  ex_mem_t   ex_mem_i,
  output dmem_req_t dmem_req_o,
  input  word_t     dmem_rdata_i,
  output reg_addr_t rd_o,
  output logic      reg_write_o,
  output word_t     result_o,
  output mem_wb_t   mem_wb_o
);

  ex_mem_t ex_mem_q;

  // Reset leaves a bubble, both strobes low
  always_ff @(posedge clk_i) begin
    if (!rst_ni) begin
      ex_mem_q <= '0;
    end else begin
      ex_mem_q <= ex_mem_i;
    end
  end

  assign dmem_req_o = '{
    addr:  ex_mem_q.alu_result,
    wdata: ex_mem_q.store_data,
    we:    ex_mem_q.mem_write,
    re:    ex_mem_q.mem_read
  };

  // Forwarding value, a load here is blocked by the load-use stall
  assign rd_o        = ex_mem_q.rd;
  assign reg_write_o = ex_mem_q.reg_write;
  assign result_o    = (ex_mem_q.result_src == RES_PC4) ? ex_mem_q.pc4 : ex_mem_q.alu_result;

  assign mem_wb_o = '{
    reg_write:  ex_mem_q.reg_write,
    result_src: ex_mem_q.result_src,
    alu_result: ex_mem_q.alu_result,
    load_data:  dmem_rdata_i,
    pc4:        ex_mem_q.pc4,
    rd:         ex_mem_q.rd
  };

endmodule

// ==== src/rv_core.sv ====
// Both memory ports must answer combinationally in the same cycle; no back-pressure is supported
`timescale 1ns/1ns
module rv_core
  import rv_pkg::*;
(
  input  logic      clk_i,
  input  logic      rst_ni,
  output word_t     imem_addr_o,
  input  word_t     imem_rdata_i,
  output dmem_req_t dmem_req_o,
  input  word_t     dmem_rdata_i
);

  // Stage bundles
  if_id_t    fetch_bus;
  id_ex_t    decoded;
  ex_mem_t   ex_mem;
  mem_wb_t   mem_wb;
  rf_write_t rf_write;

  // Hazard inputs from decode, execute and memory
  reg_addr_t id_rs1;
  reg_addr_t id_rs2;
  reg_addr_t ex_rs1;
  reg_addr_t ex_rs2;
  reg_addr_t ex_rd;
  logic      ex_mem_read;
  reg_addr_t mem_rd;
  logic      mem_reg_write;
  word_t     mem_result;

  // Redirect from execute
  logic      redirect;
  word_t     target;

  // Hazard outputs
  logic      stall;
  logic      flush_id;
  logic      bubble_ex;
  fwd_sel_e  fwd_a;
  fwd_sel_e  fwd_b;

  fetch_stage i_fetch (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .stall_i     (stall),
    .redirect_i  (redirect),
    .target_i    (target),
    .imem_addr_o (imem_addr_o),
    .imem_rdata_i(imem_rdata_i),
    .fetch_o     (fetch_bus)
  );

  decode_stage i_decode (
    .clk_i     (clk_i),
    .rst_ni    (rst_ni),
    .fetch_i   (fetch_bus),
    .stall_i   (stall),
    .flush_i   (flush_id),
    .rf_write_i(rf_write),
    .rs1_o     (id_rs1),
    .rs2_o     (id_rs2),
    .decoded_o (decoded)
  );

  execute_stage i_execute (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .decoded_i   (decoded),
    .bubble_i    (bubble_ex),
    .fwd_a_i     (fwd_a),
    .fwd_b_i     (fwd_b),
    .mem_result_i(mem_result),
    .rf_write_i  (rf_write),
    .rd_o        (ex_rd),
    .mem_read_o  (ex_mem_read),
    .rs1_o       (ex_rs1),
    .rs2_o       (ex_rs2),
    .redirect_o  (redirect),
    .target_o    (target),
    .ex_mem_o    (ex_mem)
  );

  memory_stage i_memory (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .ex_mem_i    (ex_mem),
    .dmem_req_o  (dmem_req_o),
    .dmem_rdata_i(dmem_rdata_i),
    .rd_o        (mem_rd),
    .reg_write_o (mem_reg_write),
    .result_o    (mem_result),
    .mem_wb_o    (mem_wb)
  );

  writeback_stage i_writeback (
    .clk_i     (clk_i),
    .rst_ni    (rst_ni),
    .mem_wb_i  (mem_wb),
    .rf_write_o(rf_write)
  );

  // Writeback rd and enable come from the final write request, x0 already filtered
  hazard_unit i_hazard (
    .id_rs1_i       (id_rs1),
    .id_rs2_i       (id_rs2),
    .ex_rs1_i       (ex_rs1),
    .ex_rs2_i       (ex_rs2),
    .ex_rd_i        (ex_rd),
    .ex_mem_read_i  (ex_mem_read),
    .redirect_i     (redirect),
    .mem_rd_i       (mem_rd),
    .mem_reg_write_i(mem_reg_write),
    .wb_rd_i        (rf_write.rd),
    .wb_reg_write_i (rf_write.en),
    .stall_o        (stall),
    .flush_id_o     (flush_id),
    .bubble_ex_o    (bubble_ex),
    .fwd_a_o        (fwd_a),
    .fwd_b_o        (fwd_b)
  );

endmodule

// ==== src/writeback_stage.sv ====
// Write request is combinational from the last pipeline register; x0 writes are dropped here
`timescale 1ns/1ns
module writeback_stage
  import rv_pkg::*;
(
  input  logic      clk_i,
  input  logic      rst_ni,
  input  mem_wb_t   mem_wb_i,
  output rf_write_t rf_write_o
);

  mem_wb_t mem_wb_q;
  word_t   wb_data;

  always_ff @(posedge clk_i) begin
    if (!rst_ni) begin
      mem_wb_q <= '0;
    end else begin
      mem_wb_q <= mem_wb_i;
    end
  end

  // Result select
  always_comb begin
    case (mem_wb_q.result_src)
      RES_LOAD: wb_data = mem_wb_q.load_data;
      RES_PC4:  wb_data = mem_wb_q.pc4;
      default:  wb_data = mem_wb_q.alu_result;
    endcase
  end

  // Enable doubles as the forwarding valid in execute
  assign rf_write_o = '{
    en:   mem_wb_q.reg_write && (mem_wb_q.rd != 5'd0),
    rd:   mem_wb_q.rd,
    data: wb_data
  };

endmodule

// ==== testbench/rv_core_checker.sv ====
// Port-level rules only; sampled on the rising clock, no view of internal pipeline state
`timescale 1ns/1ns
module rv_core_checker
  import rv_pkg::*;
(
  input logic      clk_i,
  input logic      rst_ni,
  input word_t     imem_addr_o,
  input dmem_req_t dmem_req_o
);

  // ====================
  // Data port strobes
  // ====================
  // A word access is either a read or a write, never both
  a_strobe_excl: assert property (@(posedge clk_i)
    !(dmem_req_o.we && dmem_req_o.re))
    else $error("data read and write strobes high together");

  // Checked from the second reset cycle on, once the pipeline registers hold bubbles
  a_reset_quiet: assert property (@(posedge clk_i)
    (!rst_ni && $past(!rst_ni)) |-> (!dmem_req_o.we && !dmem_req_o.re))
    else $error("data strobe active during reset");

  // ====================
  // Fetch address
  // ====================
  a_fetch_align: assert property (@(posedge clk_i)
    rst_ni |-> (imem_addr_o[1:0] == 2'b00))
    else $error("fetch address not word aligned");

endmodule

bind rv_core rv_core_checker u_checker (
  .clk_i      (clk_i),
  .rst_ni     (rst_ni),
  .imem_addr_o(imem_addr_o),
  .dmem_req_o (dmem_req_o)
);

// ==== testbench/tb_rv_core.sv ====
// Random programs up to 512 words; loads and stores use x0-based addresses in a 256-word window
`timescale 1ns/1ns
module tb_rv_core
  import rv_pkg::*;
;

  logic      clk_i = 1'b0;
  logic      rst_ni;
  word_t     imem_addr;
  word_t     imem_rdata;
  dmem_req_t dmem_req;
  word_t     dmem_rdata;

  // Program image shared by the core and the model
  word_t prog [512];
  bit    mid [512];
  bit    fix [512];
  word_t dmem [256];
  word_t mmem [256];
  word_t mregs [32];
  int    body_start;
  int    body_end;
  int    loop_idx;
  int    pass_count;
  int    fail_count;
  int    errs;
  // Store logs in order
  word_t core_addr [$];
  word_t core_data [$];
  word_t model_addr [$];
  word_t model_data [$];

  always #5 clk_i = ~clk_i;

  rv_core uut (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .imem_addr_o (imem_addr),
    .imem_rdata_i(imem_rdata),
    .dmem_req_o  (dmem_req),
    .dmem_rdata_i(dmem_rdata)
  );

  // Both ports answer in the same cycle
  assign imem_rdata = (imem_addr[31:11] == '0) ? prog[imem_addr[10:2]] : NOP_INSTR;
  assign dmem_rdata = dmem[dmem_req.addr[9:2]];

  // The store itself is the only access in the memory stage at its edge
  always @(posedge clk_i) begin
    if (rst_ni && dmem_req.we) begin
      dmem[dmem_req.addr[9:2]] = dmem_req.wdata;
      core_addr.push_back(dmem_req.addr);
      core_data.push_back(dmem_req.wdata);
    end
  end

  // ====================
  // Encoders
  // ====================
  function automatic word_t enc_r(logic [6:0] f7, logic [4:0] rs2, logic [4:0] rs1,
                                  logic [2:0] f3, logic [4:0] rd);
    return {f7, rs2, rs1, f3, rd, OPC_OP};
  endfunction

  function automatic word_t enc_i(logic [11:0] imm, logic [4:0] rs1, logic [2:0] f3,
                                  logic [4:0] rd, logic [6:0] opc);
    return {imm, rs1, f3, rd, opc};
  endfunction

  function automatic word_t enc_s(logic [11:0] imm, logic [4:0] rs2, logic [4:0] rs1);
    return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], OPC_STORE};
  endfunction

  function automatic word_t enc_b(logic [12:0] imm, logic [4:0] rs2, logic [4:0] rs1,
                                  logic [2:0] f3);
    return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], OPC_BRANCH};
  endfunction

  function automatic word_t enc_j(logic [20:0] imm, logic [4:0] rd);
    return {imm[20], imm[10:1], imm[11], imm[19:12], rd, OPC_JAL};
  endfunction

  function automatic logic [4:0] rnd_reg();
    return 5'(1 + ($urandom % 31));
  endfunction

  // Slot kinds 0 to 7 are OP, OPIMM, LUI, LW, SW, branch, JAL and JALR
  function automatic int pick_kind(int mode);
    int r;
    r = int'($urandom % 10);
    case (mode)
      2: return r % 3;
      3: return (r < 3) ? 3 : ((r < 5) ? 4 : r % 2);
      4: return r % 8;
      default: return (r < 4) ? 3 : ((r < 7) ? 4 : r % 2);
    endcase
  endfunction

  // ====================
  // Program generator
  // ====================
  task automatic gen_program(input int mode);
    int n;
    int i;
    int j;
    int kind;
    logic [4:0] rd;
    logic [4:0] rs1;
    logic [4:0] rs2;
    logic [4:0] last_rd;
    logic [4:0] prev_rd;
    logic [2:0] f3;
    logic [6:0] f7;
    logic [11:0] imm;
    logic [2:0] br_f3 [6];
    br_f3 = '{3'd0, 3'd1, 3'd4, 3'd5, 3'd6, 3'd7};
    for (i = 0; i < 512; i++) begin
      prog[i] = NOP_INSTR;
      mid[i] = 1'b0;
      fix[i] = 1'b0;
    end
    n = 0;
    // Every register gets a value before any read
    for (i = 1; i < 32; i++) begin
      prog[n] = enc_i(12'($urandom), 5'd0, 3'd0, 5'(i), OPC_OPIMM);
      n++;
    end
    body_start = n;
    last_rd = 5'd1;
    prev_rd = 5'd2;
    while (n < body_start + 200) begin
      kind = pick_kind(mode);
      rd = rnd_reg();
      // Dependency chains pull sources from the two latest writes
      rs1 = (mode == 3) ? (($urandom % 2) ? last_rd : prev_rd) : rnd_reg();
      rs2 = (mode == 3) ? (($urandom % 2) ? last_rd : prev_rd) : rnd_reg();
      f3 = 3'($urandom);
      f7 = (($urandom % 2) && (f3 == 3'd0 || f3 == 3'd5)) ? 7'h20 : 7'h00;
      case (kind)
        0: prog[n] = enc_r(f7, rs2, rs1, f3, rd);
        1: begin
          imm = 12'($urandom);
          if (f3 == 3'd1) begin
            imm = {7'h00, imm[4:0]};
          end else if (f3 == 3'd5) begin
            imm = {f7, imm[4:0]};
          end
          prog[n] = enc_i(imm, rs1, f3, rd, OPC_OPIMM);
        end
        2: prog[n] = {20'($urandom), rd, OPC_LUI};
        3: prog[n] = enc_i(12'(($urandom % 256) * 4), 5'd0, 3'b010, rd, OPC_LOAD);
        4: prog[n] = enc_s(12'(($urandom % 256) * 4), rs2, 5'd0);
        5: begin
          if ($urandom % 4 == 0) begin
            rs2 = rs1;
          end
          prog[n] = enc_b(13'd0, rs2, rs1, br_f3[$urandom % 6]);
          fix[n] = 1'b1;
        end
        6: begin
          prog[n] = enc_j(21'd0, rd);
          fix[n] = 1'b1;
        end
        default: begin
          // LUI, ADDI and JALR on one base register
          // Only the LUI is a safe landing point
          prog[n] = {20'd0, rs1, OPC_LUI};
          n++;
          prog[n] = enc_i(12'd0, rs1, 3'd0, rs1, OPC_OPIMM);
          mid[n] = 1'b1;
          n++;
          prog[n] = enc_i(12'd0, rs1, 3'd0, rd, OPC_JALR);
          mid[n] = 1'b1;
          fix[n] = 1'b1;
        end
      endcase
      n++;
      if (kind != 4 && kind != 5) begin
        prev_rd = last_rd;
        last_rd = rd;
      end
    end
    body_end = n;
    // Register dump followed by the final self loop
    for (i = 1; i < 32; i++) begin
      prog[n] = enc_s(12'(i * 4), 5'(i), 5'd0);
      n++;
    end
    loop_idx = n;
    prog[n] = enc_j(21'd0, 5'd0);
    // Forward targets are patched in once the whole body exists
    for (i = body_start; i < body_end; i++) begin
      if (fix[i]) begin
        j = i + 1 + int'($urandom % 4);
        if (prog[i][6:0] != OPC_JALR) begin
          j++;
        end
        if (j > body_end) begin
          j = body_end;
        end
        while (mid[j]) begin
          j++;
        end
        case (prog[i][6:0])
          OPC_BRANCH: prog[i] = enc_b(13'((j - i) * 4), prog[i][24:20], prog[i][19:15],
                                      prog[i][14:12]);
          OPC_JAL:    prog[i] = enc_j(21'((j - i) * 4), prog[i][11:7]);
          default:    prog[i - 1] = enc_i(12'(j * 4), prog[i][19:15], 3'd0,
                                          prog[i][19:15], OPC_OPIMM);
        endcase
      end
    end
  endtask

  // ====================
  // Instruction-set model
  // ====================
  function automatic word_t model_alu(logic [2:0] f3, logic alt, word_t a, word_t b);
    case (f3)
      3'd0: return alt ? a - b : a + b;
      3'd1: return a << b[4:0];
      3'd2: return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
      3'd3: return (a < b) ? 32'd1 : 32'd0;
      3'd4: return a ^ b;
      3'd5: return alt ? word_t'($signed(a) >>> b[4:0]) : a >> b[4:0];
      3'd6: return a | b;
      default: return a & b;
    endcase
  endfunction

  task automatic model_run();
    word_t pc;
    word_t nx;
    word_t ins;
    word_t a;
    word_t b;
    word_t val;
    word_t addr;
    logic  wr;
    logic  tk;
    int    steps;
    pc = RESET_PC;
    steps = 0;
    while (pc != word_t'(loop_idx * 4) && steps < 20000) begin
      ins = prog[pc[10:2]];
      a = mregs[ins[19:15]];
      b = mregs[ins[24:20]];
      nx = pc + 32'd4;
      wr = 1'b1;
      val = '0;
      case (ins[6:0])
        OPC_LUI:   val = {ins[31:12], 12'd0};
        OPC_OPIMM: val = model_alu(ins[14:12], ins[14:12] == 3'd5 && ins[30], a,
                                   {{20{ins[31]}}, ins[31:20]});
        OPC_OP:    val = model_alu(ins[14:12], ins[30], a, b);
        OPC_LOAD: begin
          addr = a + {{20{ins[31]}}, ins[31:20]};
          val = mmem[addr[9:2]];
        end
        OPC_STORE: begin
          wr = 1'b0;
          addr = a + {{20{ins[31]}}, ins[31:25], ins[11:7]};
          mmem[addr[9:2]] = b;
          model_addr.push_back(addr);
          model_data.push_back(b);
        end
        OPC_BRANCH: begin
          wr = 1'b0;
          case (ins[14:12])
            3'd0: tk = (a == b);
            3'd1: tk = (a != b);
            3'd4: tk = ($signed(a) < $signed(b));
            3'd5: tk = ($signed(a) >= $signed(b));
            3'd6: tk = (a < b);
            default: tk = (a >= b);
          endcase
          if (tk) begin
            nx = pc + {{19{ins[31]}}, ins[31], ins[7], ins[30:25], ins[11:8], 1'b0};
          end
        end
        OPC_JAL: begin
          val = pc + 32'd4;
          nx = pc + {{11{ins[31]}}, ins[31], ins[19:12], ins[20], ins[30:21], 1'b0};
        end
        default: begin
          val = pc + 32'd4;
          nx = (a + {{20{ins[31]}}, ins[31:20]}) & ~32'd1;
        end
      endcase
      if (wr && ins[11:7] != 5'd0) begin
        mregs[ins[11:7]] = val;
      end
      pc = nx;
      steps++;
    end
  endtask

  // ====================
  // Test sequences
  // ====================
  task automatic apply_reset();
    rst_ni = 1'b0;
    repeat (3) @(posedge clk_i);
    #1 rst_ni = 1'b1;
  endtask

  task automatic check_reset();
    int c;
    errs = 0;
    // Reset is low from time zero and stays low for three edges
    for (c = 0; c < 3; c++) begin
      @(posedge clk_i);
      #1;
      // Third pass releases reset and samples the first cycle after it
      if (c == 2) begin
        rst_ni = 1'b1;
      end
      if (imem_addr != RESET_PC) begin
        $display("Mismatch at %0t: imem_addr_o core=%h expected=%h", $time, imem_addr, RESET_PC);
        errs++;
      end
      if (dmem_req.we || dmem_req.re) begin
        $display("Mismatch at %0t: dmem strobes core=%b%b expected=00", $time,
                 dmem_req.we, dmem_req.re);
        errs++;
      end
    end
    report(1, "reset");
  endtask

  task automatic report(input int id, input string name);
    if (errs == 0) begin
      $display("Test %0d %s: passed", id, name);
      pass_count++;
    end else begin
      $display("Test %0d %s: failed with %0d errors", id, name, errs);
      fail_count++;
    end
  endtask

  task automatic run_test(input int id, input string name, input int mode);
    int k;
    int cycles;
    int limit;
    word_t w;
    errs = 0;
    gen_program(mode);
    for (k = 0; k < 256; k++) begin
      w = $urandom;
      dmem[k] = w;
      mmem[k] = w;
    end
    for (k = 0; k < 32; k++) begin
      mregs[k] = '0;
    end
    model_addr.delete();
    model_data.delete();
    core_addr.delete();
    core_data.delete();
    model_run();
    limit = (loop_idx + 1) * 3 + 100;
    cycles = 0;
    apply_reset();
    while (imem_addr != word_t'(loop_idx * 4)) begin
      @(posedge clk_i);
      #1 cycles++;
      if (cycles > limit) begin
        $display("Timeout: test %0d never reached its final loop in %0d cycles", id, limit);
        $display("SOME TESTS FAILED");
        $finish;
      end
    end
    // Let the register dump drain through the last stages
    repeat (8) @(posedge clk_i);
    #1;
    if (core_addr.size() != model_addr.size()) begin
      $display("Mismatch at %0t: store count core=%0d model=%0d", $time,
               core_addr.size(), model_addr.size());
      errs++;
    end else begin
      for (k = 0; k < core_addr.size(); k++) begin
        if (core_addr[k] != model_addr[k]) begin
          $display("Mismatch at %0t: store_addr[%0d] core=%h model=%h", $time, k,
                   core_addr[k], model_addr[k]);
          errs++;
        end
        if (core_data[k] != model_data[k]) begin
          $display("Mismatch at %0t: store_data[%0d] core=%h model=%h", $time, k,
                   core_data[k], model_data[k]);
          errs++;
        end
      end
    end
    report(id, name);
  endtask

  initial begin
    rst_ni = 1'b0;
    pass_count = 0;
    fail_count = 0;
    void'($urandom(32'hc713));
    for (int k = 0; k < 512; k++) begin
      prog[k] = NOP_INSTR;
    end
    check_reset();
    run_test(2, "alu and lui", 2);
    run_test(3, "forwarding and load-use", 3);
    run_test(4, "control flow", 4);
    run_test(5, "memory", 5);
    $display("Tests passed: %0d, tests failed: %0d", pass_count, fail_count);
    if (fail_count == 0) begin
      $display("ALL TESTS PASSED");
    end else begin
      $display("SOME TESTS FAILED");
    end
    $finish;
  end

endmodule
